/* Bender.yml */
package:
  name: rank_filter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rank_filter_pkg.sv
      - rtl/sort3_network.sv
      - rtl/window_decode.sv
      - rtl/sort5_pipeline.sv
      - rtl/rank_result.sv
      - rtl/rank_filter_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/rank_filter_tb.sv

/* include/rank_filter_defs.svh */
`ifndef RANK_FILTER_DEFS_SVH
`define RANK_FILTER_DEFS_SVH

// width of one sample word.
`define SAMPLE_W 8

// the sorter is built for exactly five inputs, so this stays at 5.
`define WINDOW_LEN 5

`endif

/* rtl/rank_filter_pkg.sv */
`include "rank_filter_defs.svh"

package rank_filter_pkg;

  typedef logic [`SAMPLE_W-1:0] sample_t;

  typedef enum logic [2:0] {
    RANK_MIN = 3'd0,
    RANK_2   = 3'd1,
    RANK_MED = 3'd2,
    RANK_4   = 3'd3,
    RANK_MAX = 3'd4
  } rank_sel_e;

  // s1 is the oldest sample, s5 the newest.
  typedef struct packed {
    sample_t s1;
    sample_t s2;
    sample_t s3;
    sample_t s4;
    sample_t s5;
  } window_t;

  typedef struct packed {
    logic      valid;
    rank_sel_e rank;
  } tag_t;

  typedef struct packed {
    sample_t min;
    sample_t r2;
    sample_t med;
    sample_t r4;
    sample_t max;
  } sorted_t;

endpackage

/* rtl/rank_filter_top.sv */
module rank_filter_top (
  input  logic                       clk,
  input  logic                       rst,
  input  rank_filter_pkg::sample_t   sample_i,
  input  logic                       sample_valid_i,
  input  rank_filter_pkg::rank_sel_e rank_sel_i,
  input  logic                       clear_i,
  output rank_filter_pkg::sample_t   result_o,
  output logic                       result_valid_o
);
  import rank_filter_pkg::*;

  window_t window;
  tag_t    dec_tag;
  sorted_t sorted;
  tag_t    sort_tag;

  window_decode u_decode (
    .clk            (clk),
    .rst            (rst),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .rank_sel_i     (rank_sel_i),
    .clear_i        (clear_i),
    .window_o       (window),
    .tag_o          (dec_tag)
  );

  sort5_pipeline u_sort (
    .clk      (clk),
    .rst      (rst),
    .window_i (window),
    .tag_i    (dec_tag),
    .sorted_o (sorted),
    .tag_o    (sort_tag)
  );

  rank_result u_result (
    .clk            (clk),
    .rst            (rst),
    .sorted_i       (sorted),
    .tag_i          (sort_tag),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

/* rtl/rank_result.sv */
module rank_result (
  input  logic                     clk,
  input  logic                     rst,
  input  rank_filter_pkg::sorted_t sorted_i,
  input  rank_filter_pkg::tag_t    tag_i,
  output rank_filter_pkg::sample_t result_o,
  output logic                     result_valid_o
);
  import rank_filter_pkg::*;

  sample_t pick;
  sample_t result_q;
  logic    result_valid_q;

  always_comb begin
    unique case (tag_i.rank)
      RANK_MIN: pick = sorted_i.min;
      RANK_2:   pick = sorted_i.r2;
      RANK_MED: pick = sorted_i.med;
      RANK_4:   pick = sorted_i.r4;
      RANK_MAX: pick = sorted_i.max;
      default:  pick = sorted_i.med;  // unused codes fall back to the median.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_q       <= '0;
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= tag_i.valid;
      // the output holds its last result between strobes.
      if (tag_i.valid) begin
        result_q <= pick;
      end
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

endmodule

/* rtl/sort3_network.sv */
module sort3_network (
  input  rank_filter_pkg::sample_t a_i,
  input  rank_filter_pkg::sample_t b_i,
  input  rank_filter_pkg::sample_t c_i,
  output rank_filter_pkg::sample_t max_o,
  output rank_filter_pkg::sample_t med_o,
  output rank_filter_pkg::sample_t min_o
);
  import rank_filter_pkg::*;

  sample_t hi_ab, lo_ab;  // ordered pair of a and b.
  sample_t hi_bc;         // larger of the low pair member and c.

  always_comb begin
    // first step orders a and b. a swap happens only on a strict compare.
    hi_ab = (b_i > a_i) ? b_i : a_i;
    lo_ab = (b_i > a_i) ? a_i : b_i;

    // second step pushes the smallest value down to min.
    hi_bc = (c_i > lo_ab) ? c_i : lo_ab;
    min_o = (c_i > lo_ab) ? lo_ab : c_i;

    // third step settles max and median.
    max_o = (hi_bc > hi_ab) ? hi_bc : hi_ab;
    med_o = (hi_bc > hi_ab) ? hi_ab : hi_bc;
  end

endmodule

/* rtl/sort5_pipeline.sv */
module sort5_pipeline (
  input  logic                     clk,
  input  logic                     rst,
  input  rank_filter_pkg::window_t window_i,
  input  rank_filter_pkg::tag_t    tag_i,
  output rank_filter_pkg::sorted_t sorted_o,
  output rank_filter_pkg::tag_t    tag_o
);
  import rank_filter_pkg::*;

  localparam int STAGES = 4;

  tag_t tag_q [STAGES];

  // stage 1 sorts the three oldest samples.
  sample_t sn1_max, sn1_med, sn1_min;
  sample_t p1_max, p1_med, p1_min, p1_s4, p1_s5;

  sort3_network sn1 (
    .a_i   (window_i.s1),
    .b_i   (window_i.s2),
    .c_i   (window_i.s3),
    .max_o (sn1_max),
    .med_o (sn1_med),
    .min_o (sn1_min)
  );

  always_ff @(posedge clk) begin
    p1_max <= sn1_max;
    p1_med <= sn1_med;
    p1_min <= sn1_min;
    p1_s4  <= window_i.s4;
    p1_s5  <= window_i.s5;
  end

  // stage 2 finds the overall maximum.
  sample_t sn2_max, sn2_med, sn2_min;
  sample_t p2_max, p2_med, p2_min, p2_med1, p2_min1;

  sort3_network sn2 (
    .a_i   (p1_max),
    .b_i   (p1_s4),
    .c_i   (p1_s5),
    .max_o (sn2_max),
    .med_o (sn2_med),
    .min_o (sn2_min)
  );

  always_ff @(posedge clk) begin
    p2_max  <= sn2_max;
    p2_med  <= sn2_med;
    p2_min  <= sn2_min;
    p2_med1 <= p1_med;
    p2_min1 <= p1_min;
  end

  // stage 3 finds the fourth rank among the four values left.
  sample_t sn3_max, sn3_med, sn3_min;
  sample_t p3_r4, p3_med, p3_min, p3_max_o, p3_min1;

  sort3_network sn3 (
    .a_i   (p2_med1),
    .b_i   (p2_med),
    .c_i   (p2_min),
    .max_o (sn3_max),
    .med_o (sn3_med),
    .min_o (sn3_min)
  );

  always_ff @(posedge clk) begin
    p3_r4    <= sn3_max;
    p3_med   <= sn3_med;
    p3_min   <= sn3_min;
    p3_max_o <= p2_max;
    p3_min1  <= p2_min1;
  end

  // stage 4 orders the remaining three into median, second and minimum.
  sample_t sn4_max, sn4_med, sn4_min;
  sorted_t p4_sorted;

  sort3_network sn4 (
    .a_i   (p3_min1),
    .b_i   (p3_med),
    .c_i   (p3_min),
    .max_o (sn4_max),
    .med_o (sn4_med),
    .min_o (sn4_min)
  );

  always_ff @(posedge clk) begin
    p4_sorted.min <= sn4_min;
    p4_sorted.r2  <= sn4_med;
    p4_sorted.med <= sn4_max;
    p4_sorted.r4  <= p3_r4;
    p4_sorted.max <= p3_max_o;
  end

  // the tag follows the data one register per stage.
  always_ff @(posedge clk) begin
    tag_q[0] <= tag_i;
    for (int i = 1; i < STAGES; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
    if (rst) begin
      for (int i = 0; i < STAGES; i++) begin
        tag_q[i].valid <= 1'b0;
      end
    end
  end

  assign sorted_o = p4_sorted;
  assign tag_o    = tag_q[STAGES-1];

endmodule

/* rtl/window_decode.sv */
`include "rank_filter_defs.svh"

module window_decode (
  input  logic                       clk,
  input  logic                       rst,
  input  rank_filter_pkg::sample_t   sample_i,
  input  logic                       sample_valid_i,
  input  rank_filter_pkg::rank_sel_e rank_sel_i,
  input  logic                       clear_i,
  output rank_filter_pkg::window_t   window_o,
  output rank_filter_pkg::tag_t      tag_o
);
  import rank_filter_pkg::*;

  localparam int FILL_W = $clog2(`WINDOW_LEN + 1);

  window_t           window_q;
  tag_t              tag_q;
  logic [FILL_W-1:0] fill_q;
  logic [FILL_W-1:0] fill_base;  // count that the current strobe builds on.
  logic              full_next;

  // a clear in the same cycle as a strobe makes that sample the first one.
  always_comb begin
    fill_base = clear_i ? '0 : fill_q;
    full_next = (fill_base >= FILL_W'(`WINDOW_LEN - 1));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      window_q <= '0;
      tag_q    <= '0;
      fill_q   <= '0;
    end else begin
      tag_q.valid <= sample_valid_i && full_next;
      if (sample_valid_i) begin
        window_q.s1 <= window_q.s2;
        window_q.s2 <= window_q.s3;
        window_q.s3 <= window_q.s4;
        window_q.s4 <= window_q.s5;
        window_q.s5 <= sample_i;
        tag_q.rank  <= rank_sel_i;  // rank rides with its own sample.
        if (fill_base == FILL_W'(`WINDOW_LEN)) begin
          fill_q <= fill_base;
        end else begin
          fill_q <= fill_base + 1'b1;
        end
      end else if (clear_i) begin
        fill_q <= '0;
      end
    end
  end

  assign window_o = window_q;
  assign tag_o    = tag_q;

endmodule

/* tests/rank_filter_tb.sv */
`include "rank_filter_defs.svh"

module rank_filter_tb;
  import rank_filter_pkg::*;

  localparam int LATENCY = 6;  // strobe edge to the edge that sees result_valid_o.
  localparam int LEN_RESET = 20;
  localparam int LEN_FIRST = 60;
  localparam int LEN_STREAM = 60;
  localparam int LEN_RANDOM = 420;
  localparam int LEN_EDGES = 35;
  localparam int LEN_CLEAR = 35;
  localparam int MAX_CYCLES = LEN_RESET + LEN_FIRST + LEN_STREAM + LEN_RANDOM + LEN_EDGES
                              + LEN_CLEAR + 50;

  typedef struct packed {
    logic [31:0] due;
    sample_t     value;
  } expect_t;

  logic      clk;
  logic      rst;
  sample_t   sample_i;
  logic      sample_valid_i;
  rank_sel_e rank_sel_i;
  logic      clear_i;
  sample_t   result_o;
  logic      result_valid_o;

  int        cyc = 0;
  int        seed = 32'h8eb1f89a;
  int        errors = 0;
  int        errors_before = 0;
  int        test_no = 1;
  int        n_results = 0;
  int        fill = 0;
  sample_t   model_win [`WINDOW_LEN];
  expect_t   pending [$];
  expect_t   item;
  logic      exp_valid = 1'b0;
  sample_t   exp_hold = '0;
  sample_t   edge_vals [20] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hff, 8'hff, 8'hff,
                                8'hff, 8'hff, 8'h00, 8'hff, 8'h00, 8'hff, 8'h00, 8'h07,
                                8'h03, 8'h07, 8'h03, 8'h07};

  rank_filter_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .rank_sel_i     (rank_sel_i),
    .clear_i        (clear_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // sorts a copy of the window in ascending order and returns the requested rank.
  function automatic sample_t rank_value(input sample_t win [`WINDOW_LEN], input rank_sel_e r);
    sample_t s [`WINDOW_LEN];
    sample_t t;
    s = win;
    for (int i = 1; i < `WINDOW_LEN; i++) begin
      for (int j = i; j > 0 && s[j-1] > s[j]; j--) begin
        t = s[j];
        s[j] = s[j-1];
        s[j-1] = t;
      end
    end
    return s[int'(r)];
  endfunction

  // reference model of the window, plus the expected output for the next edge.
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst) begin
      pending.delete();
      fill = 0;
      exp_valid <= 1'b0;
      exp_hold <= '0;
    end else begin
      if (clear_i) fill = 0;  // a clear with a strobe makes that sample the first one.
      if (sample_valid_i) begin
        for (int i = 0; i < `WINDOW_LEN - 1; i++) begin
          model_win[i] = model_win[i+1];
        end
        model_win[`WINDOW_LEN-1] = sample_i;
        if (fill >= `WINDOW_LEN - 1) begin
          item.due = cyc + LATENCY;
          item.value = rank_value(model_win, rank_sel_i);
          pending.push_back(item);
        end
        if (fill < `WINDOW_LEN) fill = fill + 1;
      end
      exp_valid <= 1'b0;
      if (pending.size() != 0 && pending[0].due == cyc + 1) begin
        exp_valid <= 1'b1;
        exp_hold <= pending[0].value;
        void'(pending.pop_front());
        n_results++;
      end
    end
  end

  check_valid: assert property (@(posedge clk) (cyc == 0) || (result_valid_o == exp_valid))
    else begin
      errors++;
      $display("error: result_valid_o expected %h got %h", $sampled(exp_valid),
               $sampled(result_valid_o));
    end

  // result_o holds its last value, so it is compared on every edge.
  check_value: assert property (@(posedge clk) (cyc == 0) || (result_o == exp_hold))
    else begin
      errors++;
      $display("error: result_o expected %h got %h", $sampled(exp_hold), $sampled(result_o));
    end

  always @(negedge clk) begin
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  task automatic send(input sample_t s, input rank_sel_e r, input logic clr, input int gap);
    sample_i = s;
    rank_sel_i = r;
    clear_i = clr;
    sample_valid_i = 1'b1;
    @(negedge clk);
    sample_valid_i = 1'b0;
    clear_i = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  task automatic clear_window();
    clear_i = 1'b1;
    @(negedge clk);
    clear_i = 1'b0;
  endtask

  task automatic drain();
    while (pending.size() != 0) @(negedge clk);
    @(negedge clk);  // the last result is checked on the edge before this one.
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s done, %0d errors", test_no, name, errors - errors_before);
    test_no++;
    errors_before = errors;
  endtask

  initial begin
    rst = 1'b1;
    sample_i = '0;
    sample_valid_i = 1'b0;
    rank_sel_i = RANK_MED;
    clear_i = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (10) @(negedge clk);
    end_test("reset");

    for (int i = 0; i < 5; i++) send(sample_t'($random(seed)), RANK_4, 1'b0, 1);
    drain();
    clear_window();
    for (int i = 0; i < 5; i++) send(sample_t'($random(seed)), RANK_MIN, 1'b0, 2);
    drain();
    end_test("first_window");

    for (int i = 0; i < 40; i++) send(sample_t'($random(seed)), RANK_MED, 1'b0, 0);
    drain();
    end_test("stream_median");

    for (int i = 0; i < 100; i++) begin
      send(sample_t'($random(seed)), rank_sel_e'($unsigned($random(seed)) % 5), 1'b0,
           $unsigned($random(seed)) % 4);
    end
    drain();
    end_test("random_ranks");

    for (int i = 0; i < 20; i++) send(edge_vals[i], rank_sel_e'(i % 5), 1'b0, 0);
    drain();
    end_test("edge_values");

    for (int i = 0; i < 6; i++) send(sample_t'($random(seed)), RANK_MAX, 1'b0, 0);
    send(8'h5a, RANK_MED, 1'b1, 1);
    for (int i = 0; i < 4; i++) send(sample_t'($random(seed)), RANK_2, 1'b0, 2);
    drain();
    end_test("clear_strobe");

    $display("summary: %0d tests, %0d results checked, %0d errors", test_no - 1, n_results,
             errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
rtl/rank_filter_pkg.sv
rtl/sort3_network.sv
rtl/window_decode.sv
rtl/sort5_pipeline.sv
rtl/rank_result.sv
rtl/rank_filter_top.sv
tests/rank_filter_tb.sv
